// ==== src/id_pkg.sv ====
package id_pkg;

  localparam int XLEN = 32;
  localparam int REG_IDX_WD = 5;
  localparam int ALU_OP_WD = 12;
  localparam int WIDTH_MASK_WD = 4;

  // distance from slot 0 pc to slot 1 pc
  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

  // micro-op layout, lsb first
  localparam int UOP_PC = 0;
  localparam int UOP_INE = UOP_PC + XLEN;
  localparam int UOP_UNSIGNED = UOP_INE + 1;
  localparam int UOP_MOD = UOP_UNSIGNED + 1;
  localparam int UOP_DIV = UOP_MOD + 1;
  localparam int UOP_MUL = UOP_DIV + 1;
  localparam int UOP_USE_RJ_VALUE = UOP_MUL + 1;
  localparam int UOP_NEED_ZERO = UOP_USE_RJ_VALUE + 1;
  localparam int UOP_USE_ZERO = UOP_NEED_ZERO + 1;
  localparam int UOP_NEED_LESS = UOP_USE_ZERO + 1;
  localparam int UOP_USE_LESS = UOP_NEED_LESS + 1;
  localparam int UOP_MAY_JUMP = UOP_USE_LESS + 1;
  localparam int UOP_SRC2_IS_4 = UOP_MAY_JUMP + 1;
  localparam int UOP_SRC2_IS_IMM = UOP_SRC2_IS_4 + 1;
  localparam int UOP_SRC1_IS_PC = UOP_SRC2_IS_IMM + 1;
  localparam int UOP_RES_FROM_MEM = UOP_SRC1_IS_PC + 1;
  localparam int UOP_MEM_WE = UOP_RES_FROM_MEM + 1;
  localparam int UOP_GR_WE = UOP_MEM_WE + 1;
  localparam int UOP_WIDTH = UOP_GR_WE + 1;
  localparam int UOP_RKD = UOP_WIDTH + WIDTH_MASK_WD;
  localparam int UOP_RJ = UOP_RKD + REG_IDX_WD;
  localparam int UOP_DEST = UOP_RJ + REG_IDX_WD;
  localparam int UOP_IMM = UOP_DEST + REG_IDX_WD;
  localparam int UOP_ALU = UOP_IMM + XLEN;
  localparam int UOP_WD = UOP_ALU + ALU_OP_WD;

  // bits 31:26
  localparam logic [5:0] OP6_ALU = 6'h00;
  localparam logic [5:0] OP6_LU12I = 6'h05;
  localparam logic [5:0] OP6_MEM = 6'h0a;
  localparam logic [5:0] OP6_JIRL = 6'h13;
  localparam logic [5:0] OP6_B = 6'h14;
  localparam logic [5:0] OP6_BL = 6'h15;
  localparam logic [5:0] OP6_BEQ = 6'h16;
  localparam logic [5:0] OP6_BNE = 6'h17;
  localparam logic [5:0] OP6_BLT = 6'h18;
  localparam logic [5:0] OP6_BGE = 6'h19;
  localparam logic [5:0] OP6_BLTU = 6'h1a;
  localparam logic [5:0] OP6_BGEU = 6'h1b;

  // bits 25:22, alu group
  localparam logic [3:0] OP4_3R = 4'h0;
  localparam logic [3:0] OP4_SHI = 4'h1;
  localparam logic [3:0] OP4_SLTI = 4'h8;
  localparam logic [3:0] OP4_SLTUI = 4'h9;
  localparam logic [3:0] OP4_ADDI = 4'ha;
  localparam logic [3:0] OP4_ANDI = 4'hd;
  localparam logic [3:0] OP4_ORI = 4'he;
  localparam logic [3:0] OP4_XORI = 4'hf;

  // bits 25:22, memory group
  localparam logic [3:0] OP4_LD_B = 4'h0;
  localparam logic [3:0] OP4_LD_H = 4'h1;
  localparam logic [3:0] OP4_LD_W = 4'h2;
  localparam logic [3:0] OP4_ST_B = 4'h4;
  localparam logic [3:0] OP4_ST_H = 4'h5;
  localparam logic [3:0] OP4_ST_W = 4'h6;
  localparam logic [3:0] OP4_LD_BU = 4'h8;
  localparam logic [3:0] OP4_LD_HU = 4'h9;

  // bits 21:20
  localparam logic [1:0] OP2_SHI = 2'h0;
  localparam logic [1:0] OP2_3R = 2'h1;
  localparam logic [1:0] OP2_DIV = 2'h2;

  // bits 19:15
  localparam logic [4:0] OP5_ADD = 5'h00;
  localparam logic [4:0] OP5_SUB = 5'h02;
  localparam logic [4:0] OP5_SLT = 5'h04;
  localparam logic [4:0] OP5_SLTU = 5'h05;
  localparam logic [4:0] OP5_NOR = 5'h08;
  localparam logic [4:0] OP5_AND = 5'h09;
  localparam logic [4:0] OP5_OR = 5'h0a;
  localparam logic [4:0] OP5_XOR = 5'h0b;
  localparam logic [4:0] OP5_SLL = 5'h0e;
  localparam logic [4:0] OP5_SRL = 5'h0f;
  localparam logic [4:0] OP5_SRA = 5'h10;
  localparam logic [4:0] OP5_MUL = 5'h18;
  localparam logic [4:0] OP5_DIV = 5'h00;
  localparam logic [4:0] OP5_MOD = 5'h01;
  localparam logic [4:0] OP5_SLLI = 5'h01;
  localparam logic [4:0] OP5_SRLI = 5'h09;
  localparam logic [4:0] OP5_SRAI = 5'h11;

  // one-hot alu op bit positions
  localparam int ALU_ADD = 0;
  localparam int ALU_SUB = 1;
  localparam int ALU_SLT = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND = 4;
  localparam int ALU_NOR = 5;
  localparam int ALU_OR = 6;
  localparam int ALU_XOR = 7;
  localparam int ALU_SLL = 8;
  localparam int ALU_SRL = 9;
  localparam int ALU_SRA = 10;
  localparam int ALU_LUI = 11;

  typedef struct packed {
    logic [5:0] op6;
    logic [3:0] op4;
    logic [1:0] op2;
    logic [4:0] op5;
    logic [4:0] rk;
    logic [4:0] rj;
    logic [4:0] rd;
  } instr_3r_t;

  typedef struct packed {
    logic [5:0] op6;
    logic [3:0] op4;
    logic [11:0] imm12;
    logic [4:0] rj;
    logic [4:0] rd;
  } instr_2ri12_t;

  typedef struct packed {
    logic [5:0] op6;
    logic [15:0] offs16;
    logic [4:0] rj;
    logic [4:0] rd;
  } instr_2ri16_t;

  typedef struct packed {
    logic [5:0] op6;
    logic op1;
    logic [19:0] imm20;
    logic [4:0] rd;
  } instr_1ri20_t;

  // same word seen through each format
  typedef union packed {
    instr_3r_t r3;
    instr_2ri12_t ri12;
    instr_2ri16_t ri16;
    instr_1ri20_t ri20;
  } instr_u;

endpackage

// ==== src/slot_decoder.sv ====
`timescale 1ns/1ps

module slot_decoder (
  input  id_pkg::instr_u                  instr,
  input  logic [id_pkg::XLEN-1:0]         pc,
  output logic [id_pkg::UOP_WD-1:0]       uop,
  output logic                            is_ls,
  output logic                            is_mul,
  output logic                            is_div,
  output logic                            may_jump,
  output logic                            must_single,
  output logic                            gr_we,
  output logic                            use_rj,
  output logic                            use_rkd,
  output logic [id_pkg::REG_IDX_WD-1:0]   dest,
  output logic [id_pkg::REG_IDX_WD-1:0]   rj,
  output logic [id_pkg::REG_IDX_WD-1:0]   rkd
);

  // opcode groups
  wire op_alu = instr.r3.op6 == id_pkg::OP6_ALU;
  wire op_mem = instr.ri12.op6 == id_pkg::OP6_MEM;
  wire grp_3r = op_alu && instr.r3.op4 == id_pkg::OP4_3R && instr.r3.op2 == id_pkg::OP2_3R;
  wire grp_dm = op_alu && instr.r3.op4 == id_pkg::OP4_3R && instr.r3.op2 == id_pkg::OP2_DIV;
  wire grp_shi = op_alu && instr.r3.op4 == id_pkg::OP4_SHI && instr.r3.op2 == id_pkg::OP2_SHI;

  wire inst_add = grp_3r && instr.r3.op5 == id_pkg::OP5_ADD;
  wire inst_sub = grp_3r && instr.r3.op5 == id_pkg::OP5_SUB;
  wire inst_slt = grp_3r && instr.r3.op5 == id_pkg::OP5_SLT;
  wire inst_sltu = grp_3r && instr.r3.op5 == id_pkg::OP5_SLTU;
  wire inst_nor = grp_3r && instr.r3.op5 == id_pkg::OP5_NOR;
  wire inst_and = grp_3r && instr.r3.op5 == id_pkg::OP5_AND;
  wire inst_or = grp_3r && instr.r3.op5 == id_pkg::OP5_OR;
  wire inst_xor = grp_3r && instr.r3.op5 == id_pkg::OP5_XOR;
  wire inst_sll = grp_3r && instr.r3.op5 == id_pkg::OP5_SLL;
  wire inst_srl = grp_3r && instr.r3.op5 == id_pkg::OP5_SRL;
  wire inst_sra = grp_3r && instr.r3.op5 == id_pkg::OP5_SRA;
  wire inst_mul = grp_3r && instr.r3.op5 == id_pkg::OP5_MUL;
  wire inst_div = grp_dm && instr.r3.op5 == id_pkg::OP5_DIV;
  wire inst_mod = grp_dm && instr.r3.op5 == id_pkg::OP5_MOD;
  wire inst_slli = grp_shi && instr.r3.op5 == id_pkg::OP5_SLLI;
  wire inst_srli = grp_shi && instr.r3.op5 == id_pkg::OP5_SRLI;
  wire inst_srai = grp_shi && instr.r3.op5 == id_pkg::OP5_SRAI;

  wire inst_slti = op_alu && instr.ri12.op4 == id_pkg::OP4_SLTI;
  wire inst_sltui = op_alu && instr.ri12.op4 == id_pkg::OP4_SLTUI;
  wire inst_addi = op_alu && instr.ri12.op4 == id_pkg::OP4_ADDI;
  wire inst_andi = op_alu && instr.ri12.op4 == id_pkg::OP4_ANDI;
  wire inst_ori = op_alu && instr.ri12.op4 == id_pkg::OP4_ORI;
  wire inst_xori = op_alu && instr.ri12.op4 == id_pkg::OP4_XORI;
  wire inst_lu12i = instr.ri20.op6 == id_pkg::OP6_LU12I && !instr.ri20.op1;

  wire ld_b = op_mem && instr.ri12.op4 == id_pkg::OP4_LD_B;
  wire ld_h = op_mem && instr.ri12.op4 == id_pkg::OP4_LD_H;
  wire ld_w = op_mem && instr.ri12.op4 == id_pkg::OP4_LD_W;
  wire ld_bu = op_mem && instr.ri12.op4 == id_pkg::OP4_LD_BU;
  wire ld_hu = op_mem && instr.ri12.op4 == id_pkg::OP4_LD_HU;
  wire st_b = op_mem && instr.ri12.op4 == id_pkg::OP4_ST_B;
  wire st_h = op_mem && instr.ri12.op4 == id_pkg::OP4_ST_H;
  wire st_w = op_mem && instr.ri12.op4 == id_pkg::OP4_ST_W;

  wire inst_jirl = instr.ri16.op6 == id_pkg::OP6_JIRL;
  wire inst_b = instr.ri16.op6 == id_pkg::OP6_B;
  wire inst_bl = instr.ri16.op6 == id_pkg::OP6_BL;
  wire inst_beq = instr.ri16.op6 == id_pkg::OP6_BEQ;
  wire inst_bne = instr.ri16.op6 == id_pkg::OP6_BNE;
  wire inst_blt = instr.ri16.op6 == id_pkg::OP6_BLT;
  wire inst_bge = instr.ri16.op6 == id_pkg::OP6_BGE;
  wire inst_bltu = instr.ri16.op6 == id_pkg::OP6_BLTU;
  wire inst_bgeu = instr.ri16.op6 == id_pkg::OP6_BGEU;

  wire inst_ld = ld_b | ld_h | ld_w | ld_bu | ld_hu;
  wire inst_st = st_b | st_h | st_w;
  wire br_cond = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
  wire inst_shi = inst_slli | inst_srli | inst_srai;
  wire inst_alu3r = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
                  | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;
  wire inst_alui = inst_slti | inst_sltui | inst_addi | inst_andi | inst_ori | inst_xori
                 | inst_shi | inst_lu12i;
  wire ine = !(inst_alu3r | inst_alui | inst_ld | inst_st | br_cond | inst_b | inst_bl
             | inst_jirl | inst_mul | inst_div | inst_mod);

  logic [id_pkg::ALU_OP_WD-1:0] alu_op;

  assign alu_op[id_pkg::ALU_ADD] = inst_add | inst_addi | inst_ld | inst_st | inst_jirl | inst_bl;
  assign alu_op[id_pkg::ALU_SUB] = inst_sub | inst_beq | inst_bne;
  assign alu_op[id_pkg::ALU_SLT] = inst_slt | inst_slti | inst_blt | inst_bge;
  assign alu_op[id_pkg::ALU_SLTU] = inst_sltu | inst_sltui | inst_bltu | inst_bgeu;
  assign alu_op[id_pkg::ALU_AND] = inst_and | inst_andi;
  assign alu_op[id_pkg::ALU_NOR] = inst_nor;
  assign alu_op[id_pkg::ALU_OR] = inst_or | inst_ori;
  assign alu_op[id_pkg::ALU_XOR] = inst_xor | inst_xori;
  assign alu_op[id_pkg::ALU_SLL] = inst_sll | inst_slli;
  assign alu_op[id_pkg::ALU_SRL] = inst_srl | inst_srli;
  assign alu_op[id_pkg::ALU_SRA] = inst_sra | inst_srai;
  assign alu_op[id_pkg::ALU_LUI] = inst_lu12i;

  // immediate select, branch offsets already in bytes
  wire need_si12 = inst_addi | inst_slti | inst_sltui | inst_ld | inst_st;
  wire need_ui12 = inst_andi | inst_ori | inst_xori;
  wire [25:0] offs26 = {instr.ri16.rj, instr.ri16.rd, instr.ri16.offs16};
  wire [id_pkg::XLEN-1:0] imm =
    inst_lu12i ? {instr.ri20.imm20, 12'b0} :
    inst_shi ? {27'b0, instr.r3.rk} :
    (inst_b | inst_bl) ? {{4{offs26[25]}}, offs26, 2'b00} :
    (br_cond | inst_jirl) ? {{14{instr.ri16.offs16[15]}}, instr.ri16.offs16, 2'b00} :
    need_ui12 ? {20'b0, instr.ri12.imm12} :
    need_si12 ? {{20{instr.ri12.imm12[11]}}, instr.ri12.imm12} : '0;

  wire [id_pkg::WIDTH_MASK_WD-1:0] width =
    (ld_w | st_w) ? 4'hf :
    (ld_h | ld_hu | st_h) ? 4'h3 :
    (ld_b | ld_bu | st_b) ? 4'h1 : 4'h0;

  wire src1_is_pc = inst_jirl | inst_bl;
  wire src2_is_4 = inst_jirl | inst_bl;
  wire src2_is_imm = inst_alui | inst_ld | inst_st;

  assign dest = inst_bl ? 5'd1 : instr.r3.rd;
  assign rj = instr.r3.rj;
  // stores and compare branches read rd as the second source
  assign rkd = (inst_st | br_cond) ? instr.r3.rd : instr.r3.rk;
  assign gr_we = !(inst_st | br_cond | inst_b) && (|dest);
  assign use_rj = !(inst_b | inst_bl | inst_lu12i | ine);
  assign use_rkd = inst_alu3r | inst_mul | inst_div | inst_mod | inst_st | br_cond;
  assign is_ls = inst_ld | inst_st;
  assign is_mul = inst_mul;
  assign is_div = inst_div | inst_mod;
  assign may_jump = br_cond | inst_b | inst_bl | inst_jirl;
  assign must_single = ine;

  assign uop[id_pkg::UOP_ALU +: id_pkg::ALU_OP_WD] = alu_op;
  assign uop[id_pkg::UOP_IMM +: id_pkg::XLEN] = imm;
  assign uop[id_pkg::UOP_DEST +: id_pkg::REG_IDX_WD] = dest;
  assign uop[id_pkg::UOP_RJ +: id_pkg::REG_IDX_WD] = rj;
  assign uop[id_pkg::UOP_RKD +: id_pkg::REG_IDX_WD] = rkd;
  assign uop[id_pkg::UOP_WIDTH +: id_pkg::WIDTH_MASK_WD] = width;
  assign uop[id_pkg::UOP_GR_WE] = gr_we;
  assign uop[id_pkg::UOP_MEM_WE] = inst_st;
  assign uop[id_pkg::UOP_RES_FROM_MEM] = inst_ld;
  assign uop[id_pkg::UOP_SRC1_IS_PC] = src1_is_pc;
  assign uop[id_pkg::UOP_SRC2_IS_IMM] = src2_is_imm;
  assign uop[id_pkg::UOP_SRC2_IS_4] = src2_is_4;
  assign uop[id_pkg::UOP_MAY_JUMP] = may_jump;
  assign uop[id_pkg::UOP_USE_LESS] = inst_blt | inst_bge | inst_bltu | inst_bgeu;
  assign uop[id_pkg::UOP_NEED_LESS] = inst_blt | inst_bltu;
  assign uop[id_pkg::UOP_USE_ZERO] = inst_beq | inst_bne;
  assign uop[id_pkg::UOP_NEED_ZERO] = inst_beq;
  assign uop[id_pkg::UOP_USE_RJ_VALUE] = inst_jirl;
  assign uop[id_pkg::UOP_MUL] = inst_mul;
  assign uop[id_pkg::UOP_DIV] = inst_div | inst_mod;
  assign uop[id_pkg::UOP_MOD] = inst_mod;
  assign uop[id_pkg::UOP_UNSIGNED] = ld_bu | ld_hu;
  assign uop[id_pkg::UOP_INE] = ine;
  assign uop[id_pkg::UOP_PC +: id_pkg::XLEN] = pc;

endmodule

// ==== src/dual_issue_check.sv ====
`timescale 1ns/1ps

module dual_issue_check (
  input  logic                          instr0_valid,
  input  logic                          instr1_valid,
  input  logic                          exe_ready,
  input  logic                          s0_is_ls,
  input  logic                          s0_is_mul,
  input  logic                          s0_is_div,
  input  logic                          s0_may_jump,
  input  logic                          s0_must_single,
  input  logic                          s0_gr_we,
  input  logic [id_pkg::REG_IDX_WD-1:0] s0_dest,
  input  logic                          s1_is_ls,
  input  logic                          s1_is_mul,
  input  logic                          s1_is_div,
  input  logic                          s1_may_jump,
  input  logic                          s1_must_single,
  input  logic                          s1_use_rj,
  input  logic                          s1_use_rkd,
  input  logic [id_pkg::REG_IDX_WD-1:0] s1_rj,
  input  logic [id_pkg::REG_IDX_WD-1:0] s1_rkd,
  output logic [1:0]                    pop,
  output logic                          issue0,
  output logic                          issue1
);

  logic raw;
  logic s0_long;
  logic conflict;

  // slot 1 reads what slot 0 writes, r0 never counts
  assign raw = s0_gr_we && (|s0_dest)
             && ((s1_use_rj && s0_dest == s1_rj) || (s1_use_rkd && s0_dest == s1_rkd));

  assign s0_long = s0_is_mul | s0_is_div;

  assign conflict = s0_may_jump | s0_is_ls
                  | (s0_is_mul & s1_is_mul)
                  | (s0_is_div & s1_is_div)
                  | (s0_long & (s1_is_ls | s1_may_jump))
                  | s0_must_single | s1_must_single
                  | raw;

  assign issue0 = instr0_valid & exe_ready;
  assign issue1 = issue0 & instr1_valid & ~conflict;
  assign pop = {issue1, issue0};

endmodule

// ==== src/issue_reg.sv ====
`timescale 1ns/1ps

module issue_reg (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flush,
  input  logic                        exe_ready,
  input  logic                        issue0,
  input  logic                        issue1,
  input  logic [id_pkg::UOP_WD-1:0]   uop0_next,
  input  logic [id_pkg::UOP_WD-1:0]   uop1_next,
  output logic [id_pkg::UOP_WD-1:0]   uop0,
  output logic [id_pkg::UOP_WD-1:0]   uop1,
  output logic                        uop0_valid,
  output logic                        uop1_valid
);

  // flush wins over a new issue
  always_ff @(posedge clk)
  begin
    if (rst || flush)
    begin
      uop0_valid <= 1'b0;
      uop1_valid <= 1'b0;
    end
    else if (exe_ready)
    begin
      uop0_valid <= issue0;
      uop1_valid <= issue1;
    end
  end

  // payload follows exe_ready only
  always_ff @(posedge clk)
  begin
    if (exe_ready)
    begin
      uop0 <= uop0_next;
      uop1 <= uop1_next;
    end
  end

endmodule

// ==== src/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [31:0]                 instr0,
  input  logic [31:0]                 instr1,
  input  logic [id_pkg::XLEN-1:0]     pc0,
  input  logic                        instr0_valid,
  input  logic                        instr1_valid,
  input  logic                        exe_ready,
  input  logic                        flush,
  output logic [1:0]                  pop,
  output logic [id_pkg::UOP_WD-1:0]   uop0,
  output logic [id_pkg::UOP_WD-1:0]   uop1,
  output logic                        uop0_valid,
  output logic                        uop1_valid
);

  logic [id_pkg::UOP_WD-1:0] uop0_next;
  logic [id_pkg::UOP_WD-1:0] uop1_next;
  logic s0_is_ls;
  logic s0_is_mul;
  logic s0_is_div;
  logic s0_may_jump;
  logic s0_must_single;
  logic s0_gr_we;
  logic [id_pkg::REG_IDX_WD-1:0] s0_dest;
  logic s1_is_ls;
  logic s1_is_mul;
  logic s1_is_div;
  logic s1_may_jump;
  logic s1_must_single;
  logic s1_use_rj;
  logic s1_use_rkd;
  logic [id_pkg::REG_IDX_WD-1:0] s1_rj;
  logic [id_pkg::REG_IDX_WD-1:0] s1_rkd;
  logic issue0;
  logic issue1;

  // slot 0 sources and slot 1 dest are not part of the pairing check
  slot_decoder slot0_dec_i (
    .instr       (instr0),
    .pc          (pc0),
    .uop         (uop0_next),
    .is_ls       (s0_is_ls),
    .is_mul      (s0_is_mul),
    .is_div      (s0_is_div),
    .may_jump    (s0_may_jump),
    .must_single (s0_must_single),
    .gr_we       (s0_gr_we),
    .use_rj      (),
    .use_rkd     (),
    .dest        (s0_dest),
    .rj          (),
    .rkd         ()
  );

  slot_decoder slot1_dec_i (
    .instr       (instr1),
    .pc          (pc0 + id_pkg::PC_STEP),
    .uop         (uop1_next),
    .is_ls       (s1_is_ls),
    .is_mul      (s1_is_mul),
    .is_div      (s1_is_div),
    .may_jump    (s1_may_jump),
    .must_single (s1_must_single),
    .gr_we       (),
    .use_rj      (s1_use_rj),
    .use_rkd     (s1_use_rkd),
    .dest        (),
    .rj          (s1_rj),
    .rkd         (s1_rkd)
  );

  dual_issue_check dual_issue_check_i (
    .instr0_valid   (instr0_valid),
    .instr1_valid   (instr1_valid),
    .exe_ready      (exe_ready),
    .s0_is_ls       (s0_is_ls),
    .s0_is_mul      (s0_is_mul),
    .s0_is_div      (s0_is_div),
    .s0_may_jump    (s0_may_jump),
    .s0_must_single (s0_must_single),
    .s0_gr_we       (s0_gr_we),
    .s0_dest        (s0_dest),
    .s1_is_ls       (s1_is_ls),
    .s1_is_mul      (s1_is_mul),
    .s1_is_div      (s1_is_div),
    .s1_may_jump    (s1_may_jump),
    .s1_must_single (s1_must_single),
    .s1_use_rj      (s1_use_rj),
    .s1_use_rkd     (s1_use_rkd),
    .s1_rj          (s1_rj),
    .s1_rkd         (s1_rkd),
    .pop            (pop),
    .issue0         (issue0),
    .issue1         (issue1)
  );

  issue_reg issue_reg_i (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .exe_ready  (exe_ready),
    .issue0     (issue0),
    .issue1     (issue1),
    .uop0_next  (uop0_next),
    .uop1_next  (uop1_next),
    .uop0       (uop0),
    .uop1       (uop1),
    .uop0_valid (uop0_valid),
    .uop1_valid (uop1_valid)
  );

endmodule

// ==== testbench/id_stage_vectors.svh ====
// single decodes first, then pairs, then one stalled row
task fill_table();
  add_row("add.w", r3_word(17'h20, 5'd6, 5'd5, 5'd4), 32'h0, 2'b01, 1'b1,
          2'b01, A_ADD, 32'h0, 5'd4, 1'b1, 1'b0);
  add_row("sub.w", r3_word(17'h22, 5'd9, 5'd8, 5'd7), 32'h0, 2'b01, 1'b1,
          2'b01, A_SUB, 32'h0, 5'd7, 1'b1, 1'b0);
  add_row("sltu", r3_word(17'h25, 5'd3, 5'd2, 5'd11), 32'h0, 2'b01, 1'b1,
          2'b01, A_SLTU, 32'h0, 5'd11, 1'b1, 1'b0);
  add_row("nor", r3_word(17'h28, 5'd4, 5'd3, 5'd12), 32'h0, 2'b01, 1'b1,
          2'b01, A_NOR, 32'h0, 5'd12, 1'b1, 1'b0);
  add_row("sra.w", r3_word(17'h30, 5'd6, 5'd5, 5'd18), 32'h0, 2'b01, 1'b1,
          2'b01, A_SRA, 32'h0, 5'd18, 1'b1, 1'b0);
  add_row("addi.w neg", ri12_word(10'h00a, 12'hffc, 5'd3, 5'd3), 32'h0, 2'b01, 1'b1,
          2'b01, A_ADD, 32'hffff_fffc, 5'd3, 1'b1, 1'b0);
  add_row("andi zext", ri12_word(10'h00d, 12'hfff, 5'd13, 5'd12), 32'h0, 2'b01, 1'b1,
          2'b01, A_AND, 32'h0000_0fff, 5'd12, 1'b1, 1'b0);
  add_row("ori to r0", ri12_word(10'h00e, 12'h123, 5'd1, 5'd0), 32'h0, 2'b01, 1'b1,
          2'b01, A_OR, 32'h0000_0123, 5'd0, 1'b0, 1'b0);
  add_row("slli.w", r3_word(17'h81, 5'd31, 5'd4, 5'd4), 32'h0, 2'b01, 1'b1,
          2'b01, A_SLL, 32'd31, 5'd4, 1'b1, 1'b0);
  add_row("lu12i.w", ri20_word(7'h0a, 20'habcde, 5'd20), 32'h0, 2'b01, 1'b1,
          2'b01, A_LUI, 32'habcd_e000, 5'd20, 1'b1, 1'b0);
  add_row("ld.w", ri12_word(10'h0a2, 12'hff8, 5'd7, 5'd6), 32'h0, 2'b01, 1'b1,
          2'b01, A_ADD, 32'hffff_fff8, 5'd6, 1'b1, 1'b0);
  add_row("ld.bu", ri12_word(10'h0a8, 12'h010, 5'd7, 5'd6), 32'h0, 2'b01, 1'b1,
          2'b01, A_ADD, 32'h0000_0010, 5'd6, 1'b1, 1'b0);
  add_row("st.h", ri12_word(10'h0a5, 12'h020, 5'd10, 5'd9), 32'h0, 2'b01, 1'b1,
          2'b01, A_ADD, 32'h0000_0020, 5'd9, 1'b0, 1'b0);
  add_row("beq", ri16_word(6'h16, 16'h0010, 5'd1, 5'd2), 32'h0, 2'b01, 1'b1,
          2'b01, A_SUB, 32'h0000_0040, 5'd2, 1'b0, 1'b0);
  add_row("blt neg", ri16_word(6'h18, 16'hfffe, 5'd3, 5'd4), 32'h0, 2'b01, 1'b1,
          2'b01, A_SLT, 32'hffff_fff8, 5'd4, 1'b0, 1'b0);
  add_row("b", i26_word(6'h14, 26'h000_0100), 32'h0, 2'b01, 1'b1,
          2'b01, A_NONE, 32'h0000_0400, 5'd0, 1'b0, 1'b0);
  add_row("bl to r1", i26_word(6'h15, 26'h3ff_ffff), 32'h0, 2'b01, 1'b1,
          2'b01, A_ADD, 32'hffff_fffc, 5'd1, 1'b1, 1'b0);
  add_row("jirl", ri16_word(6'h13, 16'h0004, 5'd5, 5'd1), 32'h0, 2'b01, 1'b1,
          2'b01, A_ADD, 32'h0000_0010, 5'd1, 1'b1, 1'b0);
  add_row("mul.w", r3_word(17'h38, 5'd13, 5'd12, 5'd11), 32'h0, 2'b01, 1'b1,
          2'b01, A_NONE, 32'h0, 5'd11, 1'b1, 1'b0);
  add_row("div.w", r3_word(17'h40, 5'd2, 5'd3, 5'd14), 32'h0, 2'b01, 1'b1,
          2'b01, A_NONE, 32'h0, 5'd14, 1'b1, 1'b0);
  add_row("pair indep", r3_word(17'h20, 5'd6, 5'd5, 5'd4), r3_word(17'h22, 5'd9, 5'd8, 5'd7),
          2'b11, 1'b1, 2'b11, A_ADD, 32'h0, 5'd4, 1'b1, 1'b1);
  add_row("raw rj", r3_word(17'h20, 5'd6, 5'd5, 5'd4), r3_word(17'h22, 5'd9, 5'd4, 5'd7),
          2'b11, 1'b1, 2'b01, A_ADD, 32'h0, 5'd4, 1'b1, 1'b0);
  add_row("raw rkd", r3_word(17'h20, 5'd6, 5'd5, 5'd4), r3_word(17'h22, 5'd4, 5'd8, 5'd7),
          2'b11, 1'b1, 2'b01, A_ADD, 32'h0, 5'd4, 1'b1, 1'b0);
  add_row("load slot0", ri12_word(10'h0a2, 12'hff8, 5'd7, 5'd6),
          r3_word(17'h20, 5'd12, 5'd11, 5'd10),
          2'b11, 1'b1, 2'b01, A_ADD, 32'hffff_fff8, 5'd6, 1'b1, 1'b0);
  add_row("mul mul", r3_word(17'h38, 5'd13, 5'd12, 5'd11), r3_word(17'h38, 5'd16, 5'd15, 5'd14),
          2'b11, 1'b1, 2'b01, A_NONE, 32'h0, 5'd11, 1'b1, 1'b0);
  add_row("branch slot0", ri16_word(6'h16, 16'h0010, 5'd1, 5'd2),
          r3_word(17'h20, 5'd12, 5'd11, 5'd10),
          2'b11, 1'b1, 2'b01, A_SUB, 32'h0000_0040, 5'd2, 1'b0, 1'b0);
  add_row("illegal slot0", 32'hffff_ffff, r3_word(17'h20, 5'd6, 5'd5, 5'd4),
          2'b11, 1'b1, 2'b01, A_NONE, 32'h0, 5'd31, 1'b1, 1'b0);
  add_row("illegal slot1", r3_word(17'h20, 5'd6, 5'd5, 5'd4), 32'hffff_ffff,
          2'b11, 1'b1, 2'b01, A_ADD, 32'h0, 5'd4, 1'b1, 1'b0);
  add_row("raw on r0", ri12_word(10'h00e, 12'h123, 5'd1, 5'd0),
          r3_word(17'h20, 5'd6, 5'd0, 5'd4),
          2'b11, 1'b1, 2'b11, A_OR, 32'h0000_0123, 5'd0, 1'b0, 1'b1);
  // stalled, so the registered fields stay those of the row above
  add_row("stall", r3_word(17'h22, 5'd9, 5'd8, 5'd7), r3_word(17'h20, 5'd6, 5'd5, 5'd4),
          2'b11, 1'b0, 2'b00, A_OR, 32'h0000_0123, 5'd0, 1'b0, 1'b1);
endtask

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

  localparam int DRIVE_DLY = 2;
  localparam logic [31:0] SEED = 32'ha4e4c241;

  // one-hot alu ops: add sub slt sltu and nor or xor sll srl sra lui
  localparam logic [11:0] A_NONE = 12'h000;
  localparam logic [11:0] A_ADD = 12'h001;
  localparam logic [11:0] A_SUB = 12'h002;
  localparam logic [11:0] A_SLT = 12'h004;
  localparam logic [11:0] A_SLTU = 12'h008;
  localparam logic [11:0] A_AND = 12'h010;
  localparam logic [11:0] A_NOR = 12'h020;
  localparam logic [11:0] A_OR = 12'h040;
  localparam logic [11:0] A_SLL = 12'h100;
  localparam logic [11:0] A_SRA = 12'h400;
  localparam logic [11:0] A_LUI = 12'h800;

  typedef struct packed {
    logic [31:0] instr0;
    logic [31:0] instr1;
    logic [1:0]  vld;
    logic        rdy;
    logic [1:0]  pop;
    logic [11:0] alu;
    logic [31:0] imm;
    logic [4:0]  dest;
    logic        gr_we;
    logic        uop1_valid;
  } row_t;

  logic clk;
  logic rst;
  logic [31:0] instr0;
  logic [31:0] instr1;
  logic [31:0] pc0;
  logic instr0_valid;
  logic instr1_valid;
  logic exe_ready;
  logic flush;
  logic [1:0] pop;
  logic [id_pkg::UOP_WD-1:0] uop0;
  logic [id_pkg::UOP_WD-1:0] uop1;
  logic uop0_valid;
  logic uop1_valid;

  row_t rows[$];
  string row_names[$];
  int unsigned rng_init;

  id_stage dut_i (
    .clk          (clk),
    .rst          (rst),
    .instr0       (instr0),
    .instr1       (instr1),
    .pc0          (pc0),
    .instr0_valid (instr0_valid),
    .instr1_valid (instr1_valid),
    .exe_ready    (exe_ready),
    .flush        (flush),
    .pop          (pop),
    .uop0         (uop0),
    .uop1         (uop1),
    .uop0_valid   (uop0_valid),
    .uop1_valid   (uop1_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // instruction encoders, field order as in the ISA formats
  function automatic logic [31:0] r3_word(input logic [16:0] op, input logic [4:0] rk,
                                          input logic [4:0] rj, input logic [4:0] rd);
    return {op, rk, rj, rd};
  endfunction

  function automatic logic [31:0] ri12_word(input logic [9:0] op, input logic [11:0] imm,
                                            input logic [4:0] rj, input logic [4:0] rd);
    return {op, imm, rj, rd};
  endfunction

  function automatic logic [31:0] ri16_word(input logic [5:0] op, input logic [15:0] offs,
                                            input logic [4:0] rj, input logic [4:0] rd);
    return {op, offs, rj, rd};
  endfunction

  function automatic logic [31:0] i26_word(input logic [5:0] op, input logic [25:0] offs);
    return {op, offs[15:0], offs[25:16]};
  endfunction

  function automatic logic [31:0] ri20_word(input logic [6:0] op, input logic [19:0] imm,
                                            input logic [4:0] rd);
    return {op, imm, rd};
  endfunction

  task add_row(input string name, input logic [31:0] i0, input logic [31:0] i1,
               input logic [1:0] vld, input logic rdy, input logic [1:0] exp_pop,
               input logic [11:0] alu, input logic [31:0] imm, input logic [4:0] dest,
               input logic gr_we, input logic exp_v1);
    row_t r;
    r.instr0 = i0;
    r.instr1 = i1;
    r.vld = vld;
    r.rdy = rdy;
    r.pop = exp_pop;
    r.alu = alu;
    r.imm = imm;
    r.dest = dest;
    r.gr_we = gr_we;
    r.uop1_valid = exp_v1;
    rows.push_back(r);
    row_names.push_back(name);
  endtask

  `include "id_stage_vectors.svh"

  task check_equal(input string name, input logic [127:0] expected, input logic [127:0] actual);
    if (expected !== actual)
    begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task drive_inputs(input logic [31:0] i0, input logic [31:0] i1, input logic [1:0] vld,
                    input logic rdy);
    instr0 = i0;
    instr1 = i1;
    instr0_valid = vld[0];
    instr1_valid = vld[1];
    exe_ready = rdy;
    // any word aligned pc
    pc0 = $urandom & 32'hffff_fffc;
  endtask

  task wait_pair_loaded(input int limit);
    int n;
    n = 0;
    while (!(uop0_valid && uop1_valid) && n < limit)
    begin
      @(posedge clk);
      #DRIVE_DLY;
      n++;
    end
    if (!(uop0_valid && uop1_valid))
    begin
      $display("timeout: an issued pair never showed up at the execute side");
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task apply_rows();
    row_t r;
    string nm;
    int i;
    for (i = 0; i < rows.size(); i++)
    begin
      r = rows[i];
      nm = row_names[i];
      drive_inputs(r.instr0, r.instr1, r.vld, r.rdy);
      @(negedge clk);
      check_equal({nm, " pop"}, r.pop, pop);
      @(posedge clk);
      #DRIVE_DLY;
      check_equal({nm, " uop0_valid"}, r.vld[0], uop0_valid);
      check_equal({nm, " uop1_valid"}, r.uop1_valid, uop1_valid);
      check_equal({nm, " alu"}, r.alu, uop0[id_pkg::UOP_ALU +: id_pkg::ALU_OP_WD]);
      check_equal({nm, " imm"}, r.imm, uop0[id_pkg::UOP_IMM +: id_pkg::XLEN]);
      check_equal({nm, " dest"}, r.dest, uop0[id_pkg::UOP_DEST +: id_pkg::REG_IDX_WD]);
      check_equal({nm, " gr_we"}, r.gr_we, uop0[id_pkg::UOP_GR_WE]);
    end
  endtask

  task run_backpressure();
    logic [id_pkg::UOP_WD-1:0] held0;
    logic [id_pkg::UOP_WD-1:0] held1;
    logic [31:0] pc1;
    int n;
    drive_inputs(r3_word(17'h20, 5'd6, 5'd5, 5'd4), r3_word(17'h22, 5'd9, 5'd8, 5'd7),
                 2'b11, 1'b1);
    @(posedge clk);
    #DRIVE_DLY;
    check_equal("backpressure load v0", 1, uop0_valid);
    check_equal("backpressure load v1", 1, uop1_valid);
    // slot 1 sits one word after slot 0
    pc1 = pc0 + 32'd4;
    check_equal("backpressure load pc0", pc0, uop0[id_pkg::UOP_PC +: id_pkg::XLEN]);
    check_equal("backpressure load pc1", pc1, uop1[id_pkg::UOP_PC +: id_pkg::XLEN]);
    check_equal("backpressure load alu1", A_SUB, uop1[id_pkg::UOP_ALU +: id_pkg::ALU_OP_WD]);
    check_equal("backpressure load dest1", 5'd7,
                uop1[id_pkg::UOP_DEST +: id_pkg::REG_IDX_WD]);
    held0 = uop0;
    held1 = uop1;
    for (n = 0; n < 4; n++)
    begin
      drive_inputs(r3_word(17'h38, 5'd13, 5'd12, 5'd11), r3_word(17'h40, 5'd2, 5'd3, 5'd14),
                   2'b11, 1'b0);
      @(negedge clk);
      check_equal("backpressure pop", 0, pop);
      @(posedge clk);
      #DRIVE_DLY;
      check_equal("backpressure uop0", held0, uop0);
      check_equal("backpressure uop1", held1, uop1);
      check_equal("backpressure v0", 1, uop0_valid);
      check_equal("backpressure v1", 1, uop1_valid);
    end
  endtask

  task run_flush();
    drive_inputs(32'h0, 32'h0, 2'b00, 1'b1);
    @(posedge clk);
    #DRIVE_DLY;
    check_equal("flush idle v0", 0, uop0_valid);
    drive_inputs(r3_word(17'h20, 5'd6, 5'd5, 5'd4), r3_word(17'h22, 5'd9, 5'd8, 5'd7),
                 2'b11, 1'b1);
    wait_pair_loaded(4);
    // new pair still offered while flushing
    flush = 1'b1;
    @(posedge clk);
    #DRIVE_DLY;
    check_equal("flush v0", 0, uop0_valid);
    check_equal("flush v1", 0, uop1_valid);
    flush = 1'b0;
    drive_inputs(32'h0, 32'h0, 2'b00, 1'b0);
  endtask

  initial
  begin
    rng_init = $urandom(SEED);
    rst = 1'b1;
    flush = 1'b0;
    instr0 = 32'h0;
    instr1 = 32'h0;
    pc0 = 32'h0;
    instr0_valid = 1'b0;
    instr1_valid = 1'b0;
    exe_ready = 1'b0;
    fill_table();
    repeat (8) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    check_equal("reset uop0_valid", 0, uop0_valid);
    check_equal("reset uop1_valid", 0, uop1_valid);
    apply_rows();
    run_backpressure();
    run_flush();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+testbench
src/id_pkg.sv
src/slot_decoder.sv
src/dual_issue_check.sv
src/issue_reg.sv
src/id_stage.sv
testbench/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - src/id_pkg.sv
  - src/slot_decoder.sv
  - src/dual_issue_check.sv
  - src/issue_reg.sv
  - src/id_stage.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_id_stage.sv
